// ==== sd_host.f ====
+incdir+src
src/sd_bus_pkg.sv
src/sd_line_pkg.sv
src/sd_line_if.sv
src/sd_sequencer.sv
src/sd_edge_timer.sv
src/sd_cmd_shifter.sv
src/sd_dat_collector.sv
src/sd_host.sv
tb/sd_card_model.sv
tb/tb_sd_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SD host testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module tb_sd_host -f sd_host.f -o sim_tb

# The pipe status is the one of tee, the log decides the verdict
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
	exit 1
fi

// ==== tb/tb_sd_host.sv ====
// ==============================
// SD host testbench
// Random register traffic checked
// against a pin and card model
// ==============================

`default_nettype none

`include "sd_params.svh"

module tb_sd_host
	import sd_bus_pkg::*, sd_line_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic        CARD_PRESENT   = 1'b1;
	localparam logic        CMD_IDLE       = 1'b1;
	localparam dat_nibble_t DAT_IDLE       = 4'hF;
	localparam int          TIMEOUT_CYCLES = 64 * `SD_HALF_PERIOD + 32;

	logic        clock;
	logic        reset;
	logic        request;
	logic        rw;
	reg_addr_t   address;
	bus_word_t   wdata;
	bus_word_t   rdata;
	logic        ready;
	logic        sd_clk;
	logic        cmd_dir;
	logic        card_cmd;
	logic        host_cmd;
	logic        dat_dir;
	dat_nibble_t card_dat;
	dat_nibble_t host_dat;
	logic        card_detect;

	// Reference pin state
	logic        m_clk;
	logic        m_cmd_dir;
	logic        m_dat_dir;
	logic        m_cmd;
	dat_nibble_t m_dat;
	bus_word_t   last_rdata;

	bus_word_t   result;
	bus_word_t   expected;
	bus_word_t   data;
	dat_nibble_t nib[8];
	int          iter;
	int          k;

	sd_host dut (
		.i_clock      (clock),
		.i_reset      (reset),
		.i_request    (request),
		.i_rw         (rw),
		.i_address    (address),
		.i_wdata      (wdata),
		.o_rdata      (rdata),
		.o_ready      (ready),
		.o_sd_clk     (sd_clk),
		.o_sd_cmd_dir (cmd_dir),
		.i_sd_cmd     (card_cmd),
		.o_sd_cmd     (host_cmd),
		.o_sd_dat_dir (dat_dir),
		.i_sd_dat     (card_dat),
		.o_sd_dat     (host_dat),
		.i_sd_card    (card_detect)
	);

	sd_card_model #(
		.CARD_PRESENT (CARD_PRESENT),
		.CMD_IDLE     (CMD_IDLE),
		.DAT_IDLE     (DAT_IDLE)
	) card (
		.i_sd_clk (sd_clk),
		.i_cmd    (host_cmd),
		.o_cmd    (card_cmd),
		.o_dat    (card_dat),
		.o_card   (card_detect)
	);

	always #10 clock = ~clock;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_equal(input string name, input bus_word_t exp, input bus_word_t act);
		if (exp !== act)
			abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	// One held request with optional extra hold cycles after ready
	task automatic bus_access(input logic write, input reg_addr_t addr, input bus_word_t din,
			input int hold, output bus_word_t dout);
		int waited;
		int cycle;
		@(negedge clock);
		request = 1'b1;
		rw      = write;
		address = addr;
		wdata   = din;
		waited  = 0;
		@(negedge clock);
		while (!ready) begin
			if (waited == TIMEOUT_CYCLES)
				abort_run("ready did not rise before the timeout");
			@(negedge clock);
			waited++;
		end
		dout = rdata;
		for (cycle = 0; cycle < hold; cycle++) begin
			@(negedge clock);
			check_equal("ready hold", 32'd1, {31'b0, ready});
		end
		request = 1'b0;
		waited  = 0;
		@(negedge clock);
		while (ready) begin
			if (waited == TIMEOUT_CYCLES)
				abort_run("ready stayed high after the request was released");
			@(negedge clock);
			waited++;
		end
	endtask

	function automatic bus_word_t model_status();
		logic        cmd_seen;
		dat_nibble_t dat_seen;
		cmd_seen = m_cmd_dir ? m_cmd : CMD_IDLE;
		dat_seen = m_dat_dir ? m_dat : DAT_IDLE;
		return {23'b0, CARD_PRESENT, dat_seen, cmd_seen, m_dat_dir, m_cmd_dir, m_clk};
	endfunction

	// Pin outputs against the reference pin state
	task automatic compare_pins(input string name);
		bus_word_t pins;
		pins = {24'b0, host_dat, host_cmd, dat_dir, cmd_dir, sd_clk};
		check_equal(name, {24'b0, m_dat, m_cmd, m_dat_dir, m_cmd_dir, m_clk}, pins);
	endtask

	task automatic pin_write(input bus_word_t w);
		bus_word_t unused;
		bus_access(1'b1, REG_PINS, w, 0, unused);
		m_clk     = (m_clk & ~w[8]) | w[0];
		m_cmd_dir = (m_cmd_dir & ~w[9]) | w[1];
		m_dat_dir = (m_dat_dir & ~w[10]) | w[2];
		m_cmd     = (m_cmd & ~w[11]) | w[3];
		m_dat     = (m_dat & ~w[15:12]) | w[7:4];
	endtask

	task automatic status_read(input string name, input int hold);
		bus_word_t got;
		bus_access(1'b0, REG_PINS, '0, hold, got);
		last_rdata = model_status();
		check_equal(name, last_rdata, got);
		compare_pins({name, " pins"});
	endtask

	// Two random nibbles from the card, high nibble first
	task automatic dat_byte_read(input string name);
		bus_word_t   got;
		dat_nibble_t hi;
		dat_nibble_t lo;
		hi = 4'($urandom);
		lo = 4'($urandom);
		card.push_nibble(hi);
		card.push_nibble(lo);
		bus_access(1'b0, REG_DAT_BYTE, '0, 0, got);
		m_dat_dir  = DIR_IN;
		last_rdata = {24'b0, hi, lo};
		check_equal(name, last_rdata, got);
		check_equal({name, " drain"}, 32'd0, 32'(card.pending()));
		compare_pins({name, " pins"});
	endtask

	initial begin
		void'($urandom(32'h1845_74b5));
		clock      = 1'b0;
		reset      = 1'b1;
		request    = 1'b0;
		rw         = 1'b0;
		address    = '0;
		wdata      = '0;
		m_clk      = 1'b0;
		m_cmd_dir  = DIR_IN;
		m_dat_dir  = DIR_IN;
		m_cmd      = 1'b0;
		m_dat      = '0;
		last_rdata = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		status_read("reset status", 0);

		for (iter = 0; iter < 40; iter++) begin
			pin_write($urandom);
			status_read("pin status", 0);
		end

		pin_write(32'h0000_0100);	// Park SD_CLK low before transfers
		for (iter = 0; iter < 12; iter++) begin
			data = $urandom;
			card.clear_all();
			bus_access(1'b1, REG_CMD_BYTE, data, 0, result);
			check_equal("cmd bit count", 32'd8, 32'(card.captured_count()));
			check_equal("cmd bits", {24'b0, data[7:0]}, card.captured_bits());
			m_cmd_dir = DIR_OUT;
			m_cmd     = data[0];	// Line keeps the last bit
			status_read("cmd status", 0);
		end

		for (iter = 0; iter < 12; iter++)
			dat_byte_read("dat byte");

		for (iter = 0; iter < 12; iter++) begin
			expected = '0;
			for (k = 0; k < 8; k++) begin
				nib[k] = 4'($urandom);
				card.push_nibble(nib[k]);
			end
			for (k = 0; k < 4; k++)
				expected[k*8 +: 8] = {nib[2*k], nib[2*k+1]};
			bus_access(1'b0, REG_DAT_WORD, '0, 0, result);
			m_dat_dir  = DIR_IN;
			last_rdata = expected;
			check_equal("dat word", expected, result);
			check_equal("dat word drain", 32'd0, 32'(card.pending()));
			compare_pins("dat word pins");
		end

		// Full mask write gives a known pin state with SD_CLK low
		pin_write(32'h0000_FF00 | ($urandom & 32'h0000_00FE));
		status_read("held status", 6);
		for (iter = 0; iter < 8; iter++) begin
			dat_byte_read("dat byte reload");
			bus_access(1'b0, REG_CMD_BYTE, '0, 2, result);
			check_equal("invalid read", last_rdata, result);
			bus_access(1'b1, REG_DAT_BYTE, $urandom, 2, result);
			check_equal("invalid write", last_rdata, result);
			status_read("status after invalid", 0);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/sd_card_model.sv ====
// ==============================
// Behavioral SD card
// Records CMD bits on rising SD_CLK
// and serves DAT nibbles from a queue
// ==============================

`default_nettype none

module sd_card_model
	import sd_line_pkg::*;
#(
	parameter logic        CARD_PRESENT = 1'b1,
	parameter logic        CMD_IDLE     = 1'b1,
	parameter dat_nibble_t DAT_IDLE     = 4'hF
) (
	input  logic        i_sd_clk,
	input  logic        i_cmd,
	output logic        o_cmd,
	output dat_nibble_t o_dat,
	output logic        o_card
);
	timeunit 1ns;
	timeprecision 100ps;

	logic        captured[$];
	dat_nibble_t nibbles[$];
	dat_nibble_t dat_q;

	assign o_cmd  = CMD_IDLE;	// Pulled up, card never answers
	assign o_card = CARD_PRESENT;
	assign o_dat  = dat_q;

	task automatic show_head();
		dat_q = (nibbles.size() != 0) ? nibbles[0] : DAT_IDLE;
	endtask

	task automatic push_nibble(input dat_nibble_t n);
		nibbles.push_back(n);
		show_head();
	endtask

	task automatic clear_all();
		captured.delete();
		nibbles.delete();
		show_head();
	endtask

	function automatic int pending();
		return nibbles.size();
	endfunction

	function automatic int captured_count();
		return captured.size();
	endfunction

	// Oldest bit ends up most significant
	function automatic logic [31:0] captured_bits();
		logic [31:0] bits;
		bits = '0;
		foreach (captured[i])
			bits = {bits[30:0], captured[i]};
		return bits;
	endfunction

	initial show_head();

	always @(posedge i_sd_clk)
		captured.push_back(i_cmd);

	always @(negedge i_sd_clk) begin
		if (nibbles.size() != 0)
			void'(nibbles.pop_front());
		show_head();
	end

endmodule

`default_nettype wire

// ==== src/sd_host.sv ====
// ==============================
// SD card host peripheral
// Register port to bit level card
// pins
// ==============================

`default_nettype none

module sd_host
	import sd_bus_pkg::*, sd_line_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_reset,

	input  logic        i_request,
	input  logic        i_rw,
	input  reg_addr_t   i_address,
	input  bus_word_t   i_wdata,
	output bus_word_t   o_rdata,
	output logic        o_ready,

	output logic        o_sd_clk,
	output logic        o_sd_cmd_dir,
	input  logic        i_sd_cmd,
	output logic        o_sd_cmd,
	output logic        o_sd_dat_dir,
	input  dat_nibble_t i_sd_dat,
	output dat_nibble_t o_sd_dat,
	input  logic        i_sd_card
);
	sd_line_if line ();

	assign o_sd_clk = line.sd_clk_level;

	sd_sequencer u_sequencer (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (i_request),
		.i_rw      (i_rw),
		.i_address (i_address),
		.i_wdata   (i_wdata),
		.i_sd_cmd  (i_sd_cmd),
		.i_sd_dat  (i_sd_dat),
		.i_sd_card (i_sd_card),
		.o_rdata   (o_rdata),
		.o_ready   (o_ready),
		.line      (line.seq)
	);

	sd_edge_timer u_timer (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.line    (line.timer)
	);

	sd_cmd_shifter u_cmd (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.line      (line.shifter),
		.o_cmd     (o_sd_cmd),
		.o_cmd_dir (o_sd_cmd_dir)
	);

	sd_dat_collector u_dat (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.line      (line.collector),
		.i_dat     (i_sd_dat),
		.o_dat     (o_sd_dat),
		.o_dat_dir (o_sd_dat_dir)
	);

endmodule

`default_nettype wire

// ==== src/sd_dat_collector.sv ====
// ==============================
// SD DAT line collector
// Manual pin control and nibble
// assembly into the read word
// ==============================

`default_nettype none

`include "sd_params.svh"

module sd_dat_collector
	import sd_bus_pkg::*, sd_line_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_reset,
	sd_line_if.collector line,
	input  dat_nibble_t  i_dat,
	output dat_nibble_t  o_dat,
	output logic         o_dat_dir
);
	bus_word_t   word_q;
	dat_nibble_t dat_q;
	pin_dir_e    dir_q;
	logic [2:0]  nib_idx;
	logic        active;
	logic [4:0]  slot_lsb;

	assign o_dat          = dat_q;
	assign o_dat_dir      = dir_q;
	assign line.dat_level = dat_q;
	assign line.dat_dir   = dir_q;
	assign line.rdata     = word_q;

	// Byte index times 8, high nibble first within a byte
	assign slot_lsb = {nib_idx[2:1], ~nib_idx[0], 2'b00};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			active  <= 1'b0;
			nib_idx <= '0;
			dat_q   <= '0;
			dir_q   <= DIR_IN;
		end else begin
			if (line.op == OP_DAT_START) begin
				active  <= 1'b1;
				nib_idx <= '0;
				dir_q   <= DIR_IN;
			end else if (line.op == OP_PIN_WRITE) begin
				dir_q <= pin_dir_e'((dir_q & ~line.wdata[10]) | line.wdata[2]);
				dat_q <= (dat_q & ~line.wdata[15:12]) | line.wdata[7:4];
			end else if (active) begin
				if (line.fall_strobe)
					nib_idx <= nib_idx + 3'd1;
				if (line.phase_done)
					active <= 1'b0;
			end
		end
	end

	// Sample at the end of each high phase
	always_ff @(posedge i_clock) begin
		if (line.op == OP_DAT_START)
			word_q <= '0;
		else if (active && line.fall_strobe)
			word_q[slot_lsb +: `SD_DAT_BITS] <= i_dat;
	end

endmodule

`default_nettype wire

// ==== src/sd_cmd_shifter.sv ====
// ==============================
// SD CMD line driver
// Manual pin control and MSB first
// command byte output
// ==============================

`default_nettype none

module sd_cmd_shifter
	import sd_line_pkg::*;
(
	input  logic       i_clock,
	input  logic       i_reset,
	sd_line_if.shifter line,
	output logic       o_cmd,
	output logic       o_cmd_dir
);
	cmd_byte_t shift_q;
	logic      busy;
	logic      cmd_q;
	pin_dir_e  dir_q;

	assign o_cmd          = cmd_q;
	assign o_cmd_dir      = dir_q;
	assign line.cmd_level = cmd_q;
	assign line.cmd_dir   = dir_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy  <= 1'b0;
			cmd_q <= 1'b0;
			dir_q <= DIR_IN;
		end else begin
			if (line.op == OP_CMD_START) begin
				busy  <= 1'b1;
				dir_q <= DIR_OUT;
				cmd_q <= line.wdata[7];	// First bit goes out with the first low phase
			end else if (line.op == OP_PIN_WRITE) begin
				dir_q <= pin_dir_e'((dir_q & ~line.wdata[9]) | line.wdata[1]);
				cmd_q <= (cmd_q & ~line.wdata[11]) | line.wdata[3];
			end else if (busy) begin
				if (line.fall_strobe)
					cmd_q <= shift_q[7];
				if (line.phase_done)
					busy <= 1'b0;
			end
		end
	end

	// Advance after the card samples; LSB refill keeps the last bit on the line
	always_ff @(posedge i_clock) begin
		if (line.op == OP_CMD_START)
			shift_q <= cmd_byte_t'(line.wdata[7:0]);
		else if (busy && line.rise_strobe)
			shift_q <= {shift_q[6:0], shift_q[0]};
	end

endmodule

`default_nettype wire

// ==== src/sd_edge_timer.sv ====
// ==============================
// SD clock generator
// Phase divider, edge strobes and
// end of run pulse
// ==============================

`default_nettype none

`include "sd_params.svh"

module sd_edge_timer
	import sd_line_pkg::*;
(
	input  logic     i_clock,
	input  logic     i_reset,
	sd_line_if.timer line
);
	localparam int HALF = `SD_HALF_PERIOD;
	localparam int CW = (HALF > 1) ? $clog2(HALF) : 1;

	logic [CW-1:0] cyc;
	logic [4:0]    phase;
	logic [4:0]    last_phase;
	logic          clk_q;
	logic          done_q;
	logic          active;
	logic          phase_end;

	assign active    = line.run && !done_q;
	assign phase_end = active && (cyc == CW'(HALF - 1));

	assign line.rise_strobe  = phase_end && !clk_q;
	assign line.fall_strobe  = phase_end && clk_q;	// Includes the final fall
	assign line.sd_clk_level = clk_q;
	assign line.phase_done   = done_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			clk_q      <= 1'b0;
			done_q     <= 1'b0;
			cyc        <= '0;
			phase      <= '0;
			last_phase <= '0;
		end else begin
			done_q <= 1'b0;
			if (line.op == OP_CMD_START || line.op == OP_DAT_START) begin
				// Every run starts on a low phase
				clk_q <= 1'b0;
				cyc   <= '0;
				phase <= '0;
				if (line.op == OP_CMD_START)
					last_phase <= 5'd15;
				else
					last_phase <= {line.byte_count, 2'b00} - 5'd1;
			end else if (line.op == OP_PIN_WRITE) begin
				clk_q <= (clk_q & ~line.wdata[8]) | line.wdata[0];
			end else if (active) begin
				if (phase_end) begin
					cyc   <= '0;
					clk_q <= !clk_q;
					phase <= phase + 5'd1;
					if (phase == last_phase) begin
						done_q <= 1'b1;
						phase  <= '0;
					end
				end else begin
					cyc <= cyc + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/sd_sequencer.sv ====
// ==============================
// SD host sequencer
// Decodes register accesses, runs
// transfers and returns ready
// ==============================

`default_nettype none

`include "sd_params.svh"

module sd_sequencer
	import sd_bus_pkg::*, sd_line_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_request,
	input  logic        i_rw,
	input  reg_addr_t   i_address,
	input  bus_word_t   i_wdata,
	input  logic        i_sd_cmd,
	input  dat_nibble_t i_sd_dat,
	input  logic        i_sd_card,
	output bus_word_t   o_rdata,
	output logic        o_ready,
	sd_line_if.seq      line
);
	seq_state_e  state;
	reg_sel_e    sel;
	logic        run_q;
	logic        cmd_seen;
	dat_nibble_t dat_seen;
	bus_word_t   status;

	assign sel = reg_sel_e'(i_address);

	assign line.wdata      = i_wdata;
	assign line.run        = run_q;
	assign line.byte_count = (sel == REG_DAT_WORD) ? 3'd4 : 3'd1;

	// Pins read back the card when not driven
	assign cmd_seen = (line.cmd_dir == DIR_IN) ? i_sd_cmd : line.cmd_level;
	assign dat_seen = (line.dat_dir == DIR_IN) ? i_sd_dat : line.dat_level;

	assign status = {
		{(`SD_WORD_BITS - 9){1'b0}},
		i_sd_card,
		dat_seen,
		cmd_seen,
		line.dat_dir,
		line.cmd_dir,
		line.sd_clk_level
	};

	// Op is decoded only while idle
	always_comb begin
		line.op = OP_NONE;
		if (state == IDLE && i_request) begin
			if (i_rw && sel == REG_PINS)
				line.op = OP_PIN_WRITE;
			else if (i_rw && sel == REG_CMD_BYTE)
				line.op = OP_CMD_START;
			else if (!i_rw && (sel == REG_DAT_BYTE || sel == REG_DAT_WORD))
				line.op = OP_DAT_START;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state   <= IDLE;
			run_q   <= 1'b0;
			o_ready <= 1'b0;
			o_rdata <= '0;
		end else begin
			case (state)
				IDLE: begin
					o_ready <= 1'b0;
					if (i_request) begin
						case (line.op)
							OP_CMD_START: begin
								run_q <= 1'b1;
								state <= SHIFT_CMD;
							end
							OP_DAT_START: begin
								run_q <= 1'b1;
								state <= READ_DAT;
							end
							default: begin
								// Pin access or invalid, answered at once
								if (!i_rw && sel == REG_PINS)
									o_rdata <= status;
								o_ready <= 1'b1;
								state   <= WAIT_EOT;
							end
						endcase
					end
				end

				SHIFT_CMD: begin
					if (line.phase_done) begin
						run_q   <= 1'b0;
						o_ready <= 1'b1;
						state   <= WAIT_EOT;
					end
				end

				READ_DAT: begin
					if (line.phase_done) begin
						run_q   <= 1'b0;
						o_rdata <= line.rdata;	// Last nibble landed last cycle
						o_ready <= 1'b1;
						state   <= WAIT_EOT;
					end
				end

				WAIT_EOT: begin
					o_ready <= i_request;
					if (!i_request)
						state <= IDLE;
				end

				default: begin
					run_q <= 1'b0;
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/sd_line_if.sv ====
// ==============================
// SD line control bundle
// Sequencer to line datapath
// ==============================

`default_nettype none

interface sd_line_if
	import sd_bus_pkg::*, sd_line_pkg::*;
();
	line_op_e    op;
	bus_word_t   wdata;
	logic        run;
	logic [2:0]  byte_count;	// 1 or 4

	logic        sd_clk_level;
	logic        rise_strobe;
	logic        fall_strobe;
	logic        phase_done;

	logic        cmd_level;
	pin_dir_e    cmd_dir;
	dat_nibble_t dat_level;
	pin_dir_e    dat_dir;
	bus_word_t   rdata;

	modport seq (
		output op, wdata, run, byte_count,
		input sd_clk_level, phase_done, cmd_level, cmd_dir, dat_level, dat_dir, rdata
	);

	modport timer (
		input op, wdata, run, byte_count,
		output sd_clk_level, rise_strobe, fall_strobe, phase_done
	);

	modport shifter (
		input op, wdata, rise_strobe, fall_strobe, phase_done,
		output cmd_level, cmd_dir
	);

	modport collector (
		input op, wdata, fall_strobe, phase_done,
		output rdata, dat_level, dat_dir
	);

endinterface

`default_nettype wire

// ==== src/sd_line_pkg.sv ====
// ==============================
// SD host card side types
// Line values, FSM states and ops
// ==============================

`default_nettype none

`include "sd_params.svh"

package sd_line_pkg;

	typedef logic [`SD_DAT_BITS-1:0] dat_nibble_t;

	typedef logic [7:0] cmd_byte_t;

	typedef enum logic {
		DIR_IN  = 1'b0,
		DIR_OUT = 1'b1
	} pin_dir_e;

	typedef enum logic [1:0] {
		IDLE,
		SHIFT_CMD,
		READ_DAT,
		WAIT_EOT	// Hold ready until request drops
	} seq_state_e;

	// One cycle pulse from the sequencer
	typedef enum logic [1:0] {
		OP_NONE,
		OP_PIN_WRITE,
		OP_CMD_START,
		OP_DAT_START
	} line_op_e;

endpackage

`default_nettype wire

// ==== src/sd_bus_pkg.sv ====
// ==============================
// SD host register port types
// Bus word, offset and register map
// ==============================

`default_nettype none

`include "sd_params.svh"

package sd_bus_pkg;

	typedef logic [`SD_WORD_BITS-1:0] bus_word_t;

	typedef logic [1:0] reg_addr_t;

	// Register offsets
	typedef enum logic [1:0] {
		REG_PINS     = 2'd0,	// Status read, masked pin write
		REG_CMD_BYTE = 2'd1,	// Write only
		REG_DAT_BYTE = 2'd2,	// Read only
		REG_DAT_WORD = 2'd3	// Read only
	} reg_sel_e;

endpackage

`default_nettype wire

// ==== src/sd_params.svh ====
// ==============================
// SD host build parameters
// Clock divider and bus widths
// ==============================

`ifndef SD_PARAMS_SVH
`define SD_PARAMS_SVH

// Bus clocks per SD clock phase, 1 or more
`define SD_HALF_PERIOD 1

// Register port data width
`define SD_WORD_BITS 32

// Card DAT bus width
`define SD_DAT_BITS 4

`endif
